// File: logic/exu_params.svh
// exu parameters: data and word-operation widths for the execute stage

`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// register and datapath width
`define EXU_XLEN 64

// width of the *w word operations
`define EXU_WLEN 32

`endif

// File: logic/exu_isa_pkg.sv
// exu isa package: encodings for alu operations, operand selects, branches and loads
`default_nettype none

package exu_isa_pkg;

  // alu control codes as driven by the decoder
  typedef enum logic [4:0] {
    OP_ADD      = 5'b00000,
    OP_SLL      = 5'b00001,
    OP_SLT      = 5'b00010,
    OP_COPY_IMM = 5'b00011,
    OP_XOR      = 5'b00100,
    OP_SRL      = 5'b00101,
    OP_OR       = 5'b00110,
    OP_AND      = 5'b00111,
    OP_SUB      = 5'b01000,
    OP_SLTU     = 5'b01010,
    OP_SRA      = 5'b01101,
    OP_REMU     = 5'b11001,
    OP_DIVU     = 5'b11010,
    OP_DIV      = 5'b11011,
    OP_MUL      = 5'b11100,
    OP_REM      = 5'b11101,
    OP_EBREAK   = 5'b11110,
    OP_ILLEGAL  = 5'b11111
  } alu_op_e;

  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } a_sel_e;

  typedef enum logic [1:0] {
    B_RS2  = 2'b00,
    B_IMM  = 2'b01,
    B_FOUR = 2'b10
  } b_sel_e;

  // signedness of the compare lives in the kind itself
  typedef enum logic [3:0] {
    BR_NONE = 4'b0000,
    BR_JAL  = 4'b0001,
    BR_JALR = 4'b0010,
    BR_EQ   = 4'b0100,
    BR_NE   = 4'b0101,
    BR_LT   = 4'b0110,
    BR_GE   = 4'b0111,
    BR_LTU  = 4'b1110,
    BR_GEU  = 4'b1111
  } branch_e;

  typedef enum logic [2:0] {
    LD_B  = 3'b000,
    LD_BU = 3'b001,
    LD_H  = 3'b010,
    LD_HU = 3'b011,
    LD_W  = 3'b100,
    LD_WU = 3'b101,
    LD_D  = 3'b110
  } mem_op_e;

endpackage

`default_nettype wire

// File: logic/exu_status_pkg.sv
// exu status package: reasons the execute stage stops the core
`default_nettype none

package exu_status_pkg;

  // reported together with the sticky halt flag
  typedef enum logic [1:0] {
    HALT_NONE    = 2'd0,
    HALT_EBREAK  = 2'd1,
    HALT_ILLEGAL = 2'd2
  } halt_cause_e;

endpackage

`default_nettype wire

// File: logic/exu_alu.sv
// exu alu: operand select and rv64im arithmetic, logic, shift, compare, multiply and divide
`default_nettype none
`timescale 1ns/1ps

`include "exu_params.svh"

module exu_alu (
  input  wire [`EXU_XLEN-1:0]       i_rs1,
  input  wire [`EXU_XLEN-1:0]       i_rs2,
  input  wire [`EXU_XLEN-1:0]       i_imm,
  input  wire [`EXU_XLEN-1:0]       i_pc,
  input  wire exu_isa_pkg::a_sel_e  i_a_sel,
  input  wire exu_isa_pkg::b_sel_e  i_b_sel,
  input  wire exu_isa_pkg::alu_op_e i_alu_op,
  input  wire                       i_word,
  output logic [`EXU_XLEN-1:0]      o_result
);

  localparam int XLEN = `EXU_XLEN;
  localparam int WLEN = `EXU_WLEN;
  localparam int SHW  = $clog2(XLEN);

  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] imm_op;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [SHW-1:0]  shamt;
  logic [WLEN-1:0] sra_w;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] div_a;
  logic [XLEN-1:0] div_b;
  logic [XLEN-1:0] divu_a;
  logic [XLEN-1:0] quot_s;
  logic [XLEN-1:0] rem_s;
  logic [XLEN-1:0] quot_u;
  logic [XLEN-1:0] rem_u;
  logic            div_zero;
  logic            div_ovf;
  logic [XLEN-1:0] raw;

  // word mode works on the low half, zero extended
  assign src1   = i_word ? {{(XLEN-WLEN){1'b0}}, i_rs1[WLEN-1:0]} : i_rs1;
  assign src2   = i_word ? {{(XLEN-WLEN){1'b0}}, i_rs2[WLEN-1:0]} : i_rs2;
  assign imm_op = i_word ? {{(XLEN-WLEN){1'b0}}, i_imm[WLEN-1:0]} : i_imm;

  assign src_a = (i_a_sel == exu_isa_pkg::A_PC) ? i_pc : src1;

  always_comb begin
    case (i_b_sel)
      exu_isa_pkg::B_RS2:  src_b = src2;
      exu_isa_pkg::B_IMM:  src_b = imm_op;
      exu_isa_pkg::B_FOUR: src_b = XLEN'(4);
      default:             src_b = '0;
    endcase
  end

  assign shamt   = i_word ? {1'b0, src_b[SHW-2:0]} : src_b[SHW-1:0];
  assign sra_w   = $signed(src_a[WLEN-1:0]) >>> shamt;
  assign sra_res = i_word ? {{(XLEN-WLEN){sra_w[WLEN-1]}}, sra_w}
                          : XLEN'($signed(src_a) >>> shamt);

  // signed divide sees sign-extended words, unsigned sees zero-extended
  assign div_a    = i_word ? {{(XLEN-WLEN){src_a[WLEN-1]}}, src_a[WLEN-1:0]} : src_a;
  assign div_b    = i_word ? {{(XLEN-WLEN){src_b[WLEN-1]}}, src_b[WLEN-1:0]} : src_b;
  assign divu_a   = i_word ? {{(XLEN-WLEN){1'b0}}, src_a[WLEN-1:0]} : src_a;
  assign div_zero = (div_b == '0);
  assign div_ovf  = (div_a == {1'b1, {(XLEN-1){1'b0}}}) && (&div_b);

  always_comb begin
    if (div_zero) begin
      quot_s = '1;
      rem_s  = div_a;
      quot_u = '1;
      rem_u  = divu_a;
    end else begin
      quot_s = div_ovf ? div_a : XLEN'($signed(div_a) / $signed(div_b));
      rem_s  = div_ovf ? '0 : XLEN'($signed(div_a) % $signed(div_b));
      quot_u = divu_a / src_b;
      rem_u  = divu_a % src_b;
    end
  end

  always_comb begin
    case (i_alu_op)
      exu_isa_pkg::OP_ADD:      raw = src_a + src_b;
      exu_isa_pkg::OP_SUB:      raw = src_a - src_b;
      exu_isa_pkg::OP_SLL:      raw = src_a << shamt;
      exu_isa_pkg::OP_SLT:      raw = XLEN'($signed(src_a) < $signed(src_b));
      exu_isa_pkg::OP_SLTU:     raw = XLEN'(src_a < src_b);
      exu_isa_pkg::OP_XOR:      raw = src_a ^ src_b;
      exu_isa_pkg::OP_SRL:      raw = src_a >> shamt;
      exu_isa_pkg::OP_SRA:      raw = sra_res;
      exu_isa_pkg::OP_OR:       raw = src_a | src_b;
      exu_isa_pkg::OP_AND:      raw = src_a & src_b;
      exu_isa_pkg::OP_COPY_IMM: raw = i_imm;
      exu_isa_pkg::OP_MUL:      raw = src_a * src_b;
      exu_isa_pkg::OP_DIV:      raw = quot_s;
      exu_isa_pkg::OP_DIVU:     raw = quot_u;
      exu_isa_pkg::OP_REM:      raw = rem_s;
      exu_isa_pkg::OP_REMU:     raw = rem_u;
      // ebreak and illegal produce nothing
      default:                  raw = '0;
    endcase
  end

  assign o_result = i_word ? {{(XLEN-WLEN){raw[WLEN-1]}}, raw[WLEN-1:0]} : raw;

endmodule

`default_nettype wire

// File: logic/exu_branch.sv
// exu branch unit: compares rs1 with rs2 and picks the next program counter
`default_nettype none
`timescale 1ns/1ps

`include "exu_params.svh"

module exu_branch (
  input  wire [`EXU_XLEN-1:0]       i_rs1,
  input  wire [`EXU_XLEN-1:0]       i_rs2,
  input  wire [`EXU_XLEN-1:0]       i_pc,
  input  wire [`EXU_XLEN-1:0]       i_imm,
  input  wire exu_isa_pkg::branch_e i_branch,
  output logic [`EXU_XLEN-1:0]      o_next_pc
);

  logic eq;
  logic lt;
  logic ltu;
  logic taken;

  assign eq  = (i_rs1 == i_rs2);
  assign lt  = ($signed(i_rs1) < $signed(i_rs2));
  assign ltu = (i_rs1 < i_rs2);

  always_comb begin
    case (i_branch)
      exu_isa_pkg::BR_JAL:  taken = 1'b1;
      exu_isa_pkg::BR_EQ:   taken = eq;
      exu_isa_pkg::BR_NE:   taken = !eq;
      exu_isa_pkg::BR_LT:   taken = lt;
      exu_isa_pkg::BR_GE:   taken = !lt;
      exu_isa_pkg::BR_LTU:  taken = ltu;
      exu_isa_pkg::BR_GEU:  taken = !ltu;
      default:              taken = 1'b0;
    endcase
  end

  // jalr target keeps bit 0 as computed
  assign o_next_pc = (i_branch == exu_isa_pkg::BR_JALR) ? i_rs1 + i_imm
                   : taken ? i_pc + i_imm
                   : i_pc + `EXU_XLEN'(4);

endmodule

`default_nettype wire

// File: logic/exu_writeback.sv
// exu write-back: load extension, result select, sticky halt and the output register
`default_nettype none
`timescale 1ns/1ps

`include "exu_params.svh"

module exu_writeback (
  input  wire                              i_clk,
  input  wire                              i_rst,
  input  wire                              i_valid,
  input  wire exu_isa_pkg::alu_op_e        i_alu_op,
  input  wire exu_isa_pkg::mem_op_e        i_mem_op,
  input  wire                              i_mem_to_reg,
  input  wire [`EXU_XLEN-1:0]              i_rdata,
  input  wire [`EXU_XLEN-1:0]              i_alu_result,
  input  wire [`EXU_XLEN-1:0]              i_next_pc,
  output logic                             o_valid,
  output logic [`EXU_XLEN-1:0]             o_alu_result,
  output logic [`EXU_XLEN-1:0]             o_next_pc,
  output logic [`EXU_XLEN-1:0]             o_wb_data,
  output logic                             o_halt,
  output exu_status_pkg::halt_cause_e      o_halt_cause
);

  localparam int XLEN = `EXU_XLEN;

  logic [XLEN-1:0]             load_ext;
  logic [XLEN-1:0]             wb_data;
  exu_status_pkg::halt_cause_e cause;
  logic                        accept;

  // nothing is taken once halted
  assign accept = i_valid && !o_halt;

  always_comb begin
    case (i_mem_op)
      exu_isa_pkg::LD_B:  load_ext = {{(XLEN-8){i_rdata[7]}}, i_rdata[7:0]};
      exu_isa_pkg::LD_BU: load_ext = {{(XLEN-8){1'b0}}, i_rdata[7:0]};
      exu_isa_pkg::LD_H:  load_ext = {{(XLEN-16){i_rdata[15]}}, i_rdata[15:0]};
      exu_isa_pkg::LD_HU: load_ext = {{(XLEN-16){1'b0}}, i_rdata[15:0]};
      exu_isa_pkg::LD_W:  load_ext = {{(XLEN-32){i_rdata[31]}}, i_rdata[31:0]};
      exu_isa_pkg::LD_WU: load_ext = {{(XLEN-32){1'b0}}, i_rdata[31:0]};
      default:            load_ext = i_rdata;
    endcase
  end

  assign wb_data = i_mem_to_reg ? load_ext : i_alu_result;

  always_comb begin
    case (i_alu_op)
      exu_isa_pkg::OP_EBREAK:  cause = exu_status_pkg::HALT_EBREAK;
      exu_isa_pkg::OP_ILLEGAL: cause = exu_status_pkg::HALT_ILLEGAL;
      default:                 cause = exu_status_pkg::HALT_NONE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid      <= 1'b0;
      o_halt       <= 1'b0;
      o_halt_cause <= exu_status_pkg::HALT_NONE;
    end else begin
      o_valid <= accept;
      if (accept && cause != exu_status_pkg::HALT_NONE) begin
        o_halt       <= 1'b1;
        o_halt_cause <= cause;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_alu_result <= i_alu_result;
      o_next_pc    <= i_next_pc;
      o_wb_data    <= wb_data;
    end
  end

  a_halt_has_cause: assert property (@(posedge i_clk) disable iff (i_rst)
    o_halt |-> o_halt_cause != exu_status_pkg::HALT_NONE);

  // the halting instruction itself is the last one out
  a_no_valid_after_halt: assert property (@(posedge i_clk) disable iff (i_rst)
    o_halt |=> !o_valid);

  a_halt_sticky: assert property (@(posedge i_clk) disable iff (i_rst)
    o_halt |=> o_halt);

endmodule

`default_nettype wire

// File: logic/exu_top.sv
// exu top: execute stage with alu, branch unit and registered write-back
`default_nettype none
`timescale 1ns/1ps

`include "exu_params.svh"

module exu_top (
  input  wire                         i_clk,
  input  wire                         i_rst,
  input  wire                         i_valid,
  input  wire [`EXU_XLEN-1:0]         i_rs1,
  input  wire [`EXU_XLEN-1:0]         i_rs2,
  input  wire [`EXU_XLEN-1:0]         i_imm,
  input  wire [`EXU_XLEN-1:0]         i_pc,
  input  wire exu_isa_pkg::a_sel_e    i_a_sel,
  input  wire exu_isa_pkg::b_sel_e    i_b_sel,
  input  wire exu_isa_pkg::alu_op_e   i_alu_op,
  input  wire                         i_word,
  input  wire exu_isa_pkg::branch_e   i_branch,
  input  wire exu_isa_pkg::mem_op_e   i_mem_op,
  input  wire                         i_mem_to_reg,
  input  wire [`EXU_XLEN-1:0]         i_rdata,
  output logic                        o_valid,
  output logic [`EXU_XLEN-1:0]        o_alu_result,
  output logic [`EXU_XLEN-1:0]        o_next_pc,
  output logic [`EXU_XLEN-1:0]        o_wb_data,
  output logic                        o_halt,
  output exu_status_pkg::halt_cause_e o_halt_cause
);

  logic [`EXU_XLEN-1:0] alu_result;
  logic [`EXU_XLEN-1:0] next_pc;

  exu_alu u_alu (
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .i_imm    (i_imm),
    .i_pc     (i_pc),
    .i_a_sel  (i_a_sel),
    .i_b_sel  (i_b_sel),
    .i_alu_op (i_alu_op),
    .i_word   (i_word),
    .o_result (alu_result)
  );

  exu_branch u_branch (
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_pc      (i_pc),
    .i_imm     (i_imm),
    .i_branch  (i_branch),
    .o_next_pc (next_pc)
  );

  exu_writeback u_writeback (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_alu_op     (i_alu_op),
    .i_mem_op     (i_mem_op),
    .i_mem_to_reg (i_mem_to_reg),
    .i_rdata      (i_rdata),
    .i_alu_result (alu_result),
    .i_next_pc    (next_pc),
    .o_valid      (o_valid),
    .o_alu_result (o_alu_result),
    .o_next_pc    (o_next_pc),
    .o_wb_data    (o_wb_data),
    .o_halt       (o_halt),
    .o_halt_cause (o_halt_cause)
  );

endmodule

`default_nettype wire

// File: verif/exu_checker.sv
// exu checker comparing the execute stage against a reference model and counting errors
`default_nettype none
`timescale 1ns/1ps

`include "exu_params.svh"

module exu_checker (
  input  wire                              i_clk,
  input  wire                              i_rst,
  input  wire                              i_valid,
  input  wire [`EXU_XLEN-1:0]              i_rs1,
  input  wire [`EXU_XLEN-1:0]              i_rs2,
  input  wire [`EXU_XLEN-1:0]              i_imm,
  input  wire [`EXU_XLEN-1:0]              i_pc,
  input  wire exu_isa_pkg::a_sel_e         i_a_sel,
  input  wire exu_isa_pkg::b_sel_e         i_b_sel,
  input  wire exu_isa_pkg::alu_op_e        i_alu_op,
  input  wire                              i_word,
  input  wire exu_isa_pkg::branch_e        i_branch,
  input  wire exu_isa_pkg::mem_op_e        i_mem_op,
  input  wire                              i_mem_to_reg,
  input  wire [`EXU_XLEN-1:0]              i_rdata,
  input  wire                              i_res_valid,
  input  wire [`EXU_XLEN-1:0]              i_alu_result,
  input  wire [`EXU_XLEN-1:0]              i_next_pc,
  input  wire [`EXU_XLEN-1:0]              i_wb_data,
  input  wire                              i_halt,
  input  wire exu_status_pkg::halt_cause_e i_halt_cause,
  output int                               o_errors,
  output int                               o_pending
);

  int                          errors = 0;
  int                          cycle = 0;
  logic                        seen_reset = 1'b0;
  logic                        rst_q = 1'b0;
  logic                        exp_halt = 1'b0;
  exu_status_pkg::halt_cause_e exp_cause = exu_status_pkg::HALT_NONE;
  int                          q_cycle[$];
  logic [`EXU_XLEN-1:0]        q_alu[$];
  logic [`EXU_XLEN-1:0]        q_pc[$];
  logic [`EXU_XLEN-1:0]        q_wb[$];
  logic [`EXU_XLEN-1:0]        res;

  // riscv divide rules on operands already widened for word mode
  function automatic logic [63:0] div_rem(input logic [63:0] x, input logic [63:0] y,
                                          input logic sgn, input logic rem, input logic word);
    logic signed [63:0] sx;
    logic signed [63:0] sy;
    logic [63:0]        most_neg;
    sx = x;
    sy = y;
    most_neg = word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
    if (y == 64'd0) return rem ? x : '1;
    if (sgn && x == most_neg && y == '1) return rem ? 64'd0 : x;
    if (sgn) return rem ? 64'(sx % sy) : 64'(sx / sy);
    return rem ? x % y : x / y;
  endfunction

  function automatic logic [63:0] alu_model(input logic [63:0] rs1, input logic [63:0] rs2,
                                            input logic [63:0] imm, input logic [63:0] pc,
                                            input exu_isa_pkg::a_sel_e a_sel,
                                            input exu_isa_pkg::b_sel_e b_sel,
                                            input exu_isa_pkg::alu_op_e op, input logic word);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] r;
    logic [5:0]  sh;
    logic        sgn;
    a = (a_sel == exu_isa_pkg::A_PC) ? pc : word ? 64'(rs1[31:0]) : rs1;
    case (b_sel)
      exu_isa_pkg::B_RS2: b = word ? 64'(rs2[31:0]) : rs2;
      exu_isa_pkg::B_IMM: b = word ? 64'(imm[31:0]) : imm;
      default:            b = 64'd4;
    endcase
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    sgn = (op == exu_isa_pkg::OP_DIV) || (op == exu_isa_pkg::OP_REM);
    x = !word ? a : sgn ? 64'($signed(a[31:0])) : 64'(a[31:0]);
    y = !word ? b : sgn ? 64'($signed(b[31:0])) : 64'(b[31:0]);
    case (op)
      exu_isa_pkg::OP_ADD:      r = a + b;
      exu_isa_pkg::OP_SUB:      r = a - b;
      exu_isa_pkg::OP_SLL:      r = a << sh;
      exu_isa_pkg::OP_SLT:      r = 64'($signed(a) < $signed(b));
      exu_isa_pkg::OP_SLTU:     r = 64'(a < b);
      exu_isa_pkg::OP_XOR:      r = a ^ b;
      exu_isa_pkg::OP_SRL:      r = a >> sh;
      exu_isa_pkg::OP_SRA:      r = word ? 64'($signed(a[31:0]) >>> sh) : 64'($signed(a) >>> sh);
      exu_isa_pkg::OP_OR:       r = a | b;
      exu_isa_pkg::OP_AND:      r = a & b;
      exu_isa_pkg::OP_COPY_IMM: r = imm;
      exu_isa_pkg::OP_MUL:      r = a * b;
      exu_isa_pkg::OP_DIV:      r = div_rem(x, y, 1'b1, 1'b0, word);
      exu_isa_pkg::OP_DIVU:     r = div_rem(x, y, 1'b0, 1'b0, word);
      exu_isa_pkg::OP_REM:      r = div_rem(x, y, 1'b1, 1'b1, word);
      exu_isa_pkg::OP_REMU:     r = div_rem(x, y, 1'b0, 1'b1, word);
      default:                  r = 64'd0;
    endcase
    return word ? 64'($signed(r[31:0])) : r;
  endfunction

  function automatic logic [63:0] branch_target(input logic [63:0] rs1, input logic [63:0] rs2,
                                                input logic [63:0] pc, input logic [63:0] imm,
                                                input exu_isa_pkg::branch_e kind);
    logic take;
    case (kind)
      exu_isa_pkg::BR_JALR: return rs1 + imm;
      exu_isa_pkg::BR_JAL:  take = 1'b1;
      exu_isa_pkg::BR_EQ:   take = (rs1 == rs2);
      exu_isa_pkg::BR_NE:   take = (rs1 != rs2);
      exu_isa_pkg::BR_LT:   take = ($signed(rs1) < $signed(rs2));
      exu_isa_pkg::BR_GE:   take = ($signed(rs1) >= $signed(rs2));
      exu_isa_pkg::BR_LTU:  take = (rs1 < rs2);
      exu_isa_pkg::BR_GEU:  take = (rs1 >= rs2);
      default:              take = 1'b0;
    endcase
    return take ? pc + imm : pc + 64'd4;
  endfunction

  function automatic logic [63:0] load_extend(input exu_isa_pkg::mem_op_e kind,
                                              input logic [63:0] d);
    case (kind)
      exu_isa_pkg::LD_B:  return 64'($signed(d[7:0]));
      exu_isa_pkg::LD_BU: return 64'(d[7:0]);
      exu_isa_pkg::LD_H:  return 64'($signed(d[15:0]));
      exu_isa_pkg::LD_HU: return 64'(d[15:0]);
      exu_isa_pkg::LD_W:  return 64'($signed(d[31:0]));
      exu_isa_pkg::LD_WU: return 64'(d[31:0]);
      default:            return d;
    endcase
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic complain(input string what);
    $display("ERROR at cycle %0d: %s", cycle, what);
    errors++;
  endtask

  // outputs seen at an edge belong to the instruction taken one edge earlier
  always @(posedge i_clk) begin
    cycle++;
    if (rst_q) begin
      compare("reset", 64'd0, 64'(i_res_valid));
      compare("reset", 64'd0, 64'(i_halt));
      compare("reset", 64'(exu_status_pkg::HALT_NONE), 64'(i_halt_cause));
    end else if (seen_reset) begin
      compare("halt", 64'(exp_halt), 64'(i_halt));
      compare("halt", 64'(exp_cause), 64'(i_halt_cause));
      if (i_res_valid === 1'b1) begin
        if (q_cycle.size() == 0) begin
          complain("o_valid came with no instruction pending");
        end else begin
          compare("latency", 64'(cycle - 1), 64'(q_cycle.pop_front()));
          compare("alu", q_alu.pop_front(), i_alu_result);
          compare("branch", q_pc.pop_front(), i_next_pc);
          compare("writeback", q_wb.pop_front(), i_wb_data);
        end
      end else if (q_cycle.size() != 0 && q_cycle[0] == cycle - 1) begin
        complain("o_valid did not arrive one cycle after the instruction");
      end
    end
    if (i_rst) begin
      seen_reset = 1'b1;
      exp_halt   = 1'b0;
      exp_cause  = exu_status_pkg::HALT_NONE;
      q_cycle.delete();
      q_alu.delete();
      q_pc.delete();
      q_wb.delete();
    end else if (seen_reset && i_valid && !exp_halt) begin
      res = alu_model(i_rs1, i_rs2, i_imm, i_pc, i_a_sel, i_b_sel, i_alu_op, i_word);
      q_cycle.push_back(cycle);
      q_alu.push_back(res);
      q_pc.push_back(branch_target(i_rs1, i_rs2, i_pc, i_imm, i_branch));
      q_wb.push_back(i_mem_to_reg ? load_extend(i_mem_op, i_rdata) : res);
      if (i_alu_op == exu_isa_pkg::OP_EBREAK) begin
        exp_halt  = 1'b1;
        exp_cause = exu_status_pkg::HALT_EBREAK;
      end else if (i_alu_op == exu_isa_pkg::OP_ILLEGAL) begin
        exp_halt  = 1'b1;
        exp_cause = exu_status_pkg::HALT_ILLEGAL;
      end
    end
    rst_q = i_rst;
    o_errors  <= errors;
    o_pending <= q_cycle.size();
  end

endmodule

`default_nettype wire

// File: verif/tb_exu.sv
// exu testbench: clock, reset, lcg stimulus, the execute stage and its checker
`default_nettype none
`timescale 1ns/1ps

`include "exu_params.svh"

module tb_exu;

  logic                        clk;
  logic                        rst;
  logic                        valid;
  logic [`EXU_XLEN-1:0]        rs1;
  logic [`EXU_XLEN-1:0]        rs2;
  logic [`EXU_XLEN-1:0]        imm;
  logic [`EXU_XLEN-1:0]        pc;
  logic [`EXU_XLEN-1:0]        rdata;
  exu_isa_pkg::a_sel_e         a_sel;
  exu_isa_pkg::b_sel_e         b_sel;
  exu_isa_pkg::alu_op_e        alu_op;
  logic                        word;
  exu_isa_pkg::branch_e        branch;
  exu_isa_pkg::mem_op_e        mem_op;
  logic                        mem_to_reg;
  logic                        out_valid;
  logic [`EXU_XLEN-1:0]        alu_result;
  logic [`EXU_XLEN-1:0]        next_pc;
  logic [`EXU_XLEN-1:0]        wb_data;
  logic                        halt;
  exu_status_pkg::halt_cause_e halt_cause;
  int                          check_errors;
  int                          pending;
  int                          timeouts;
  logic [31:0]                 lcg_state;

  // opcodes that never halt
  localparam exu_isa_pkg::alu_op_e run_ops [16] = '{
    exu_isa_pkg::OP_ADD, exu_isa_pkg::OP_SUB, exu_isa_pkg::OP_SLL, exu_isa_pkg::OP_SLT,
    exu_isa_pkg::OP_SLTU, exu_isa_pkg::OP_XOR, exu_isa_pkg::OP_SRL, exu_isa_pkg::OP_SRA,
    exu_isa_pkg::OP_OR, exu_isa_pkg::OP_AND, exu_isa_pkg::OP_COPY_IMM, exu_isa_pkg::OP_MUL,
    exu_isa_pkg::OP_DIV, exu_isa_pkg::OP_DIVU, exu_isa_pkg::OP_REM, exu_isa_pkg::OP_REMU};

  localparam exu_isa_pkg::branch_e branch_kinds [9] = '{
    exu_isa_pkg::BR_NONE, exu_isa_pkg::BR_JAL, exu_isa_pkg::BR_JALR, exu_isa_pkg::BR_EQ,
    exu_isa_pkg::BR_NE, exu_isa_pkg::BR_LT, exu_isa_pkg::BR_GE, exu_isa_pkg::BR_LTU,
    exu_isa_pkg::BR_GEU};

  exu_top DUT (
    .i_clk(clk), .i_rst(rst), .i_valid(valid), .i_rs1(rs1), .i_rs2(rs2), .i_imm(imm),
    .i_pc(pc), .i_a_sel(a_sel), .i_b_sel(b_sel), .i_alu_op(alu_op), .i_word(word),
    .i_branch(branch), .i_mem_op(mem_op), .i_mem_to_reg(mem_to_reg), .i_rdata(rdata),
    .o_valid(out_valid), .o_alu_result(alu_result), .o_next_pc(next_pc),
    .o_wb_data(wb_data), .o_halt(halt), .o_halt_cause(halt_cause)
  );

  exu_checker u_checker (
    .i_clk(clk), .i_rst(rst), .i_valid(valid), .i_rs1(rs1), .i_rs2(rs2), .i_imm(imm),
    .i_pc(pc), .i_a_sel(a_sel), .i_b_sel(b_sel), .i_alu_op(alu_op), .i_word(word),
    .i_branch(branch), .i_mem_op(mem_op), .i_mem_to_reg(mem_to_reg), .i_rdata(rdata),
    .i_res_valid(out_valid), .i_alu_result(alu_result), .i_next_pc(next_pc),
    .i_wb_data(wb_data), .i_halt(halt), .i_halt_cause(halt_cause),
    .o_errors(check_errors), .o_pending(pending)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // zero, minus one and the most negative values come up often
  function automatic logic [63:0] biased_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[31:29])
      3'd0:    return 64'd0;
      3'd1:    return '1;
      3'd2:    return 64'h8000_0000_0000_0000;
      3'd3:    return 64'hffff_ffff_8000_0000;
      3'd4:    return 64'(r[13:8]);
      default: return {next_rand(), next_rand()};
    endcase
  endfunction

  task automatic issue(input logic v, input exu_isa_pkg::alu_op_e op);
    logic [63:0] a;
    logic [31:0] r;
    a = biased_operand();
    r = next_rand();
    @(posedge clk);
    valid      <= v;
    rs1        <= a;
    // equal operands now and then so eq and ge branches are taken
    rs2        <= (r[28:27] == 2'd0) ? a : biased_operand();
    imm        <= biased_operand();
    pc         <= {next_rand(), next_rand()};
    a_sel      <= exu_isa_pkg::a_sel_e'(r[31]);
    b_sel      <= exu_isa_pkg::b_sel_e'(r[26:24] % 3);
    alu_op     <= op;
    word       <= r[30];
    branch     <= branch_kinds[r[23:16] % 9];
    mem_op     <= exu_isa_pkg::mem_op_e'(r[15:8] % 7);
    mem_to_reg <= r[29];
    rdata      <= biased_operand();
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      valid <= 1'b0;
    end
  endtask

  task automatic hold_reset();
    rst   <= 1'b1;
    valid <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic await_halt();
    int n;
    n = 0;
    while (halt !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (halt !== 1'b1) begin
      $display("ERROR: o_halt did not rise after the halting instruction");
      timeouts++;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pending != 0 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (pending != 0) begin
      $display("ERROR: instructions still waiting for o_valid at the end of the run");
      timeouts++;
    end
  endtask

  initial begin
    logic [31:0] r;
    lcg_state  = 32'h4d38b57d;
    timeouts   = 0;
    rst        = 1'b1;
    valid      = 1'b0;
    rs1        = '0;
    rs2        = '0;
    imm        = '0;
    pc         = '0;
    rdata      = '0;
    a_sel      = exu_isa_pkg::A_RS1;
    b_sel      = exu_isa_pkg::B_RS2;
    alu_op     = exu_isa_pkg::OP_ADD;
    word       = 1'b0;
    branch     = exu_isa_pkg::BR_NONE;
    mem_op     = exu_isa_pkg::LD_D;
    mem_to_reg = 1'b0;
    hold_reset();
    for (int i = 0; i < 2000; i++) begin
      r = next_rand();
      issue(r[31:29] != 3'd0, run_ops[r[27:24]]);
    end
    issue(1'b1, exu_isa_pkg::OP_EBREAK);
    // valid inputs after the halt must be dropped
    repeat (8) issue(1'b1, run_ops[next_rand() >> 28]);
    await_halt();
    idle(2);
    hold_reset();
    issue(1'b1, exu_isa_pkg::OP_ILLEGAL);
    repeat (4) issue(1'b1, run_ops[next_rand() >> 28]);
    await_halt();
    idle(3);
    drain();
    $display("errors: %0d from checks, %0d from timeouts", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/exu_isa_pkg.sv
logic/exu_status_pkg.sv
logic/exu_alu.sv
logic/exu_branch.sv
logic/exu_writeback.sv
logic/exu_top.sv
verif/exu_checker.sv
verif/tb_exu.sv

// File: Makefile
TOP = tb_exu

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
